//--- hw/xm_regs_pkg.sv
`default_nettype none

package xm_regs_pkg;

    localparam int REG_NUM_W = 4;               // register number bits
    localparam int BYTE_W    = 8;               // cpu bus byte
    localparam int WORD_W    = 16;              // register word

    typedef logic [REG_NUM_W-1:0] reg_num_t;

    // register map, xr and rw entries decode but do nothing
    localparam reg_num_t XM_XR_ADDR   = 4'd0;
    localparam reg_num_t XM_XR_DATA   = 4'd1;
    localparam reg_num_t XM_RD_INCR   = 4'd2;
    localparam reg_num_t XM_RD_ADDR   = 4'd3;
    localparam reg_num_t XM_WR_INCR   = 4'd4;
    localparam reg_num_t XM_WR_ADDR   = 4'd5;
    localparam reg_num_t XM_DATA      = 4'd6;
    localparam reg_num_t XM_DATA_2    = 4'd7;
    localparam reg_num_t XM_SYS_CTRL  = 4'd8;
    localparam reg_num_t XM_TIMER     = 4'd9;   // timer gone, reads zero
    localparam reg_num_t XM_UNUSED_A  = 4'd10;
    localparam reg_num_t XM_UNUSED_B  = 4'd11;
    localparam reg_num_t XM_RW_INCR   = 4'd12;
    localparam reg_num_t XM_RW_ADDR   = 4'd13;
    localparam reg_num_t XM_RW_DATA   = 4'd14;
    localparam reg_num_t XM_RW_DATA_2 = 4'd15;

    // SYS_CTRL fields, positions within the even byte
    localparam int SYSCTRL_NIBMASK_LSB = 0;     // write nibble mask low bit
    localparam int SYSCTRL_NIBMASK_W   = 4;     // one bit per nibble

endpackage

`default_nettype wire

//--- hw/vram_pkg.sv
`default_nettype none

package vram_pkg;

    localparam int VRAM_ADDR_W = 16;            // word address
    localparam int VRAM_DATA_W = 16;            // one word per access
    localparam int NIB_W       = 4;             // nibbles per word

    // all nibbles writable out of reset
    localparam logic [NIB_W-1:0] NIBMASK_RESET = '1;

endpackage

`default_nettype wire

//--- hw/bus_sync.sv
`default_nettype none
`timescale 1ns/1ps

module bus_sync #(
    parameter int SYNC_STAGES = 2                               // flops on cs_n, 2 or more
) (
    input  wire logic                               clk,
    input  wire logic                               reset_i,
    input  wire logic                               cs_n_i,       // async chip select
    input  wire logic                               rd_nwr_i,     // 1 read, 0 write
    input  wire xm_regs_pkg::reg_num_t              reg_num_i,
    input  wire logic                               bytesel_i,    // 0 even, 1 odd
    input  wire logic [xm_regs_pkg::BYTE_W-1:0]     data_i,
    output      logic                               wr_stb_o,     // byte write pulse
    output      logic                               rd_stb_o,     // byte read pulse
    output      xm_regs_pkg::reg_num_t              reg_num_o,    // held until next access
    output      logic                               bytesel_o,
    output      logic [xm_regs_pkg::BYTE_W-1:0]     byte_data_o
);

    logic [SYNC_STAGES-1:0] cs_sync;    // [0] sees the pin first
    logic                   cs_prev;    // last synced level
    logic                   cs_fall;    // registered falling edge

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_sync   <= '1;            // deselected
            cs_prev   <= 1'b1;
            cs_fall   <= 1'b0;
            wr_stb_o  <= 1'b0;
            rd_stb_o  <= 1'b0;
            reg_num_o <= '0;            // keeps the readback mux defined
            bytesel_o <= 1'b0;
        end else begin
            cs_sync  <= {cs_sync[SYNC_STAGES-2:0], cs_n_i};
            cs_prev  <= cs_sync[SYNC_STAGES-1];
            cs_fall  <= cs_prev & ~cs_sync[SYNC_STAGES-1];     // high to low
            wr_stb_o <= cs_fall & ~rd_nwr_i;
            rd_stb_o <= cs_fall & rd_nwr_i;
            if (cs_fall) begin
                reg_num_o <= reg_num_i;         // bus fields stable while cs low
                bytesel_o <= bytesel_i;
            end
        end
    end

    // data byte, captured with the other fields
    always_ff @(posedge clk) begin
        if (cs_fall) begin
            byte_data_o <= data_i;
        end
    end

endmodule

`default_nettype wire

//--- hw/word_assembler.sv
`default_nettype none
`timescale 1ns/1ps

module word_assembler (
    input  wire logic                               clk,
    input  wire logic                               reset_i,
    input  wire logic                               wr_stb_i,
    input  wire logic                               rd_stb_i,
    input  wire xm_regs_pkg::reg_num_t              reg_num_i,
    input  wire logic                               bytesel_i,
    input  wire logic [xm_regs_pkg::BYTE_W-1:0]     byte_data_i,
    output      logic                               word_wr_stb_o,  // odd byte written
    output      logic                               word_rd_stb_o,  // odd byte read
    output      xm_regs_pkg::reg_num_t              word_reg_o,
    output      logic [xm_regs_pkg::WORD_W-1:0]     word_data_o
);

    import xm_regs_pkg::*;

    logic [BYTE_W-1:0] data_even;       // even byte of DATA / DATA_2
    logic [BYTE_W-1:0] other_even;      // even byte of any other reg
    reg_num_t          other_reg;       // which reg other_even belongs to
    logic [BYTE_W-1:0] even_byte;       // high byte for the word
    logic              is_data;

    assign is_data = (reg_num_i == XM_DATA) || (reg_num_i == XM_DATA_2);

    // stale even byte from another register is dropped
    always_comb begin
        if (is_data) begin
            even_byte = data_even;
        end else if (other_reg == reg_num_i) begin
            even_byte = other_even;
        end else begin
            even_byte = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            data_even     <= '0;
            other_even    <= '0;
            other_reg     <= '0;
            word_wr_stb_o <= 1'b0;
            word_rd_stb_o <= 1'b0;
        end else begin
            word_wr_stb_o <= wr_stb_i & bytesel_i;      // odd byte completes the word
            word_rd_stb_o <= rd_stb_i & bytesel_i;
            if (wr_stb_i && !bytesel_i) begin
                if (is_data) begin
                    data_even  <= byte_data_i;
                end else begin
                    other_even <= byte_data_i;
                    other_reg  <= reg_num_i;
                end
            end
        end
    end

    // word payload, follows the strobes
    always_ff @(posedge clk) begin
        if ((wr_stb_i || rd_stb_i) && bytesel_i) begin
            word_reg_o  <= reg_num_i;
            word_data_o <= {even_byte, byte_data_i};
        end
    end

endmodule

`default_nettype wire

//--- hw/vram_access.sv
`default_nettype none
`timescale 1ns/1ps

module vram_access (
    input  wire logic                                   clk,
    input  wire logic                                   reset_i,
    input  wire logic                                   word_wr_stb_i,
    input  wire logic                                   word_rd_stb_i,
    input  wire xm_regs_pkg::reg_num_t                  word_reg_i,
    input  wire logic [xm_regs_pkg::WORD_W-1:0]         word_data_i,
    input  wire logic                                   vgen_sel_i,     // video owns vram
    output      logic                                   vram_sel_o,
    output      logic                                   vram_wr_o,      // 1 write, 0 read
    output      logic [vram_pkg::VRAM_ADDR_W-1:0]       vram_addr_o,
    output      logic [vram_pkg::VRAM_DATA_W-1:0]       vram_data_o,
    output      logic [vram_pkg::NIB_W-1:0]             vram_mask_o,    // nibble write enables
    output      logic                                   rd_ack_o,       // read data on vram bus
    output      logic [xm_regs_pkg::WORD_W-1:0]         rd_addr_o,
    output      logic [xm_regs_pkg::WORD_W-1:0]         rd_incr_o,
    output      logic [xm_regs_pkg::WORD_W-1:0]         wr_addr_o,
    output      logic [xm_regs_pkg::WORD_W-1:0]         wr_incr_o
);

    import xm_regs_pkg::*;
    import vram_pkg::*;

    logic is_data_reg;      // DATA or DATA_2
    logic issue_wr;         // data write to WR_ADDR
    logic issue_ld_rd;      // RD_ADDR load, read at new address
    logic issue_pref;       // odd DATA read, prefetch at RD_ADDR
    logic accept;           // vram takes the request this cycle

    assign is_data_reg = (word_reg_i == XM_DATA) || (word_reg_i == XM_DATA_2);
    assign issue_wr    = word_wr_stb_i & is_data_reg;
    assign issue_ld_rd = word_wr_stb_i & (word_reg_i == XM_RD_ADDR);
    assign issue_pref  = word_rd_stb_i & is_data_reg;
    assign accept      = vram_sel_o & ~vgen_sel_i;      // held while video has the slot

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_sel_o  <= 1'b0;
            vram_wr_o   <= 1'b0;
            vram_mask_o <= NIBMASK_RESET;
            rd_ack_o    <= 1'b0;
            rd_addr_o   <= '0;
            rd_incr_o   <= '0;
            wr_addr_o   <= '0;
            wr_incr_o   <= '0;
        end else begin
            rd_ack_o <= accept & ~vram_wr_o;            // data valid next cycle

            // completed request, post-increment its address
            if (accept) begin
                vram_sel_o <= 1'b0;
                vram_wr_o  <= 1'b0;
                if (vram_wr_o) begin
                    wr_addr_o <= wr_addr_o + wr_incr_o;
                end else begin
                    rd_addr_o <= rd_addr_o + rd_incr_o;
                end
            end

            if (word_wr_stb_i) begin
                case (word_reg_i)
                    XM_RD_INCR:  rd_incr_o <= word_data_i;
                    XM_RD_ADDR:  rd_addr_o <= word_data_i;     // read issued below
                    XM_WR_INCR:  wr_incr_o <= word_data_i;
                    XM_WR_ADDR:  wr_addr_o <= word_data_i;
                    XM_SYS_CTRL: begin
                        // mask sits in the even (high) byte
                        vram_mask_o <= word_data_i[BYTE_W+SYSCTRL_NIBMASK_LSB +: SYSCTRL_NIBMASK_W];
                    end
                    default: ;                                  // data regs and dropped regs
                endcase
            end

            // new request, never overlaps a pending one
            if (issue_wr || issue_ld_rd || issue_pref) begin
                vram_sel_o <= 1'b1;
                vram_wr_o  <= issue_wr;
            end
        end
    end

    // request address and data
    always_ff @(posedge clk) begin
        if (issue_wr) begin
            vram_addr_o <= wr_addr_o;
            vram_data_o <= word_data_i;
        end else if (issue_ld_rd) begin
            vram_addr_o <= word_data_i;         // read at the address just written
        end else if (issue_pref) begin
            vram_addr_o <= rd_addr_o;           // next word for the following DATA read
        end
    end

endmodule

`default_nettype wire

//--- hw/readback_mux.sv
`default_nettype none
`timescale 1ns/1ps

module readback_mux (
    input  wire logic                               clk,
    input  wire logic                               reset_i,
    input  wire logic                               rd_ack_i,       // vram_data_i valid
    input  wire logic [vram_pkg::VRAM_DATA_W-1:0]   vram_data_i,
    input  wire xm_regs_pkg::reg_num_t              reg_num_i,
    input  wire logic                               bytesel_i,      // 0 high byte, 1 low
    input  wire logic [xm_regs_pkg::WORD_W-1:0]     rd_addr_i,
    input  wire logic [xm_regs_pkg::WORD_W-1:0]     rd_incr_i,
    input  wire logic [xm_regs_pkg::WORD_W-1:0]     wr_addr_i,
    input  wire logic [xm_regs_pkg::WORD_W-1:0]     wr_incr_i,
    input  wire logic [vram_pkg::NIB_W-1:0]         mask_i,
    output      logic [xm_regs_pkg::BYTE_W-1:0]     bus_data_o
);

    import xm_regs_pkg::*;
    import vram_pkg::*;

    logic [VRAM_DATA_W-1:0] rd_word;        // last word read from vram
    logic [BYTE_W-1:0]      sysctrl_even;   // mask field in its even byte
    logic [WORD_W-1:0]      sel_word;       // word of the addressed register

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_word <= '0;
        end else if (rd_ack_i) begin
            rd_word <= vram_data_i;
        end
    end

    assign sysctrl_even = BYTE_W'(mask_i) << SYSCTRL_NIBMASK_LSB;

    always_comb begin
        case (reg_num_i)
            XM_RD_INCR:             sel_word = rd_incr_i;
            XM_RD_ADDR:             sel_word = rd_addr_i;
            XM_WR_INCR:             sel_word = wr_incr_i;
            XM_WR_ADDR:             sel_word = wr_addr_i;
            XM_DATA, XM_DATA_2:     sel_word = rd_word;
            XM_SYS_CTRL:            sel_word = {sysctrl_even, BYTE_W'(0)};   // odd byte empty
            default:                sel_word = '0;                         // xr, timer, rw
        endcase
    end

    assign bus_data_o = bytesel_i ? sel_word[BYTE_W-1:0] : sel_word[WORD_W-1:BYTE_W];

endmodule

`default_nettype wire

//--- hw/xm_front_top.sv
`default_nettype none
`timescale 1ns/1ps

module xm_front_top #(
    parameter int SYNC_STAGES = 2
) (
    input  wire logic                               clk,
    input  wire logic                               reset_i,
    input  wire logic                               cs_n_i,
    input  wire logic                               rd_nwr_i,
    input  wire xm_regs_pkg::reg_num_t              reg_num_i,
    input  wire logic                               bytesel_i,
    input  wire logic [xm_regs_pkg::BYTE_W-1:0]     data_i,
    input  wire logic                               vgen_sel_i,
    input  wire logic [vram_pkg::VRAM_DATA_W-1:0]   vram_data_i,
    output      logic [xm_regs_pkg::BYTE_W-1:0]     bus_data_o,
    output      logic                               vram_sel_o,
    output      logic                               vram_wr_o,
    output      logic [vram_pkg::VRAM_ADDR_W-1:0]   vram_addr_o,
    output      logic [vram_pkg::VRAM_DATA_W-1:0]   vram_data_o,
    output      logic [vram_pkg::NIB_W-1:0]         vram_mask_o
);

    import xm_regs_pkg::*;

    logic              wr_stb, rd_stb;          // byte strobes
    reg_num_t          reg_num;
    logic              bytesel;
    logic [BYTE_W-1:0] byte_data;
    logic              word_wr_stb, word_rd_stb;
    reg_num_t          word_reg;
    logic [WORD_W-1:0] word_data;
    logic              rd_ack;
    logic [WORD_W-1:0] rd_addr, rd_incr, wr_addr, wr_incr;

    bus_sync #(.SYNC_STAGES(SYNC_STAGES)) u_bus_sync (
        .clk(clk), .reset_i(reset_i),
        .cs_n_i(cs_n_i), .rd_nwr_i(rd_nwr_i), .reg_num_i(reg_num_i),
        .bytesel_i(bytesel_i), .data_i(data_i),
        .wr_stb_o(wr_stb), .rd_stb_o(rd_stb), .reg_num_o(reg_num),
        .bytesel_o(bytesel), .byte_data_o(byte_data)
    );

    word_assembler u_word_asm (
        .clk(clk), .reset_i(reset_i),
        .wr_stb_i(wr_stb), .rd_stb_i(rd_stb), .reg_num_i(reg_num),
        .bytesel_i(bytesel), .byte_data_i(byte_data),
        .word_wr_stb_o(word_wr_stb), .word_rd_stb_o(word_rd_stb),
        .word_reg_o(word_reg), .word_data_o(word_data)
    );

    vram_access u_vram_access (
        .clk(clk), .reset_i(reset_i),
        .word_wr_stb_i(word_wr_stb), .word_rd_stb_i(word_rd_stb),
        .word_reg_i(word_reg), .word_data_i(word_data), .vgen_sel_i(vgen_sel_i),
        .vram_sel_o(vram_sel_o), .vram_wr_o(vram_wr_o), .vram_addr_o(vram_addr_o),
        .vram_data_o(vram_data_o), .vram_mask_o(vram_mask_o), .rd_ack_o(rd_ack),
        .rd_addr_o(rd_addr), .rd_incr_o(rd_incr), .wr_addr_o(wr_addr), .wr_incr_o(wr_incr)
    );

    readback_mux u_readback (
        .clk(clk), .reset_i(reset_i),
        .rd_ack_i(rd_ack), .vram_data_i(vram_data_i),
        .reg_num_i(reg_num), .bytesel_i(bytesel),
        .rd_addr_i(rd_addr), .rd_incr_i(rd_incr), .wr_addr_i(wr_addr), .wr_incr_i(wr_incr),
        .mask_i(vram_mask_o), .bus_data_o(bus_data_o)
    );

endmodule

`default_nettype wire

//--- verif/xm_front_sva.sv
`default_nettype none
`timescale 1ns/1ps

module xm_front_sva (
    input wire logic                               clk,
    input wire logic                               reset_i,
    input wire logic                               vgen_sel_i,
    input wire logic                               vram_sel_i,     // dut vram_sel_o
    input wire logic                               vram_wr_i,
    input wire logic [vram_pkg::VRAM_ADDR_W-1:0]   vram_addr_i,
    input wire logic [vram_pkg::VRAM_DATA_W-1:0]   vram_data_i     // write data, not read data
);

    // a write is always part of a request
    wr_needs_sel: assert property (@(posedge clk) disable iff (reset_i)
        vram_wr_i |-> vram_sel_i)
        else $error("vram_wr_o high without vram_sel_o");

    // request frozen while the video side has the slot
    hold_on_stall: assert property (@(posedge clk) disable iff (reset_i)
        (vram_sel_i && vgen_sel_i) |=>
            ($stable(vram_addr_i) && $stable(vram_data_i) && $stable(vram_wr_i)))
        else $error("vram request changed while stalled");

    sel_low_in_reset: assert property (@(posedge clk)
        reset_i |=> !vram_sel_i)
        else $error("vram_sel_o high during reset");

    // first cycle out of reset, no request yet
    sel_low_after_reset: assert property (@(posedge clk)
        $fell(reset_i) |=> !vram_sel_i)
        else $error("vram_sel_o high right after reset");

endmodule

bind xm_front_top xm_front_sva u_sva (
    .clk(clk),
    .reset_i(reset_i),
    .vgen_sel_i(vgen_sel_i),
    .vram_sel_i(vram_sel_o),
    .vram_wr_i(vram_wr_o),
    .vram_addr_i(vram_addr_o),
    .vram_data_i(vram_data_o)
);

`default_nettype wire

//--- verif/tb_xm_front.sv
`default_nettype none
`timescale 1ns/1ps

module tb_xm_front;

    import xm_regs_pkg::*;
    import vram_pkg::*;

    localparam int  SYNC_STAGES = 2;
    localparam real CLK_PERIOD  = 4.0;
    localparam int  ACCESS_CYC  = SYNC_STAGES + 3 + 4;                 // cs low, then cs high
    localparam int  TOTAL_CYC   = 12 + ACCESS_CYC * (16 + 20 + 16 + 12 + 26 + 10) + 24;

    logic                   clk;
    logic                   reset_i;
    logic                   cs_n_i;
    logic                   rd_nwr_i;
    reg_num_t               reg_num_i;
    logic                   bytesel_i;
    logic [BYTE_W-1:0]      data_i;
    logic                   vgen_sel_i;
    logic [VRAM_DATA_W-1:0] vram_data_i;
    logic [BYTE_W-1:0]      bus_data_o;
    logic                   vram_sel_o;
    logic                   vram_wr_o;
    logic [VRAM_ADDR_W-1:0] vram_addr_o;
    logic [VRAM_DATA_W-1:0] vram_data_o;
    logic [NIB_W-1:0]       vram_mask_o;

    logic [15:0] mem [0:65535];         // vram model contents
    logic [15:0] wr_addr_q[$];          // recorded vram writes
    logic [15:0] wr_data_q[$];
    logic [3:0]  wr_mask_q[$];
    logic [15:0] rd_addr_q[$];          // recorded vram reads
    logic [15:0] lfsr_state = 16'd20;
    int          errors = 0;
    int          err_mark;
    int          tests_run = 0;
    int          tests_failed = 0;
    string       cur_test;

    xm_front_top #(.SYNC_STAGES(SYNC_STAGES)) UUT (
        .clk(clk), .reset_i(reset_i),
        .cs_n_i(cs_n_i), .rd_nwr_i(rd_nwr_i), .reg_num_i(reg_num_i),
        .bytesel_i(bytesel_i), .data_i(data_i), .vgen_sel_i(vgen_sel_i),
        .vram_data_i(vram_data_i), .bus_data_o(bus_data_o),
        .vram_sel_o(vram_sel_o), .vram_wr_o(vram_wr_o), .vram_addr_o(vram_addr_o),
        .vram_data_o(vram_data_o), .vram_mask_o(vram_mask_o)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // fibonacci lfsr, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [15:0] fill_word(input logic [15:0] a);
        return (a * 16'h9E37) ^ 16'h5AC3;                              // every address bit counts
    endfunction

    // vram model, samples at the edge, answers just after it
    always @(posedge clk) begin
        logic        acc;
        logic        wr;
        logic [15:0] a;
        logic [15:0] d;
        logic [3:0]  m;
        acc = vram_sel_o && !vgen_sel_i && !reset_i;
        wr  = vram_wr_o;
        a   = vram_addr_o;
        d   = vram_data_o;
        m   = vram_mask_o;
        #0.5;
        if (acc && wr) begin
            wr_addr_q.push_back(a);
            wr_data_q.push_back(d);
            wr_mask_q.push_back(m);
            for (int i = 0; i < 4; i++) begin
                if (m[i]) mem[a][4*i +: 4] = d[4*i +: 4];              // nibble enables
            end
        end else if (acc) begin
            rd_addr_q.push_back(a);
            vram_data_i = mem[a];
        end
    end

    task automatic check_word(input string what, input logic [15:0] exp, input logic [15:0] act);
        assert (exp === act) else begin
            $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input logic cond, input string what);
        assert (cond) else begin
            $display("%s: %s did not hold", cur_test, what);
            errors++;
        end
    endtask

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #0.5;
    endtask

    // one byte on the cpu bus, read data sampled before cs rises
    task automatic bus_byte(input logic rd, input reg_num_t r, input logic bsel,
                            input logic [7:0] din, output logic [7:0] dout);
        cs_n_i    = 1'b0;
        rd_nwr_i  = rd;
        reg_num_i = r;
        bytesel_i = bsel;
        data_i    = din;
        step(SYNC_STAGES + 3);
        dout   = bus_data_o;
        cs_n_i = 1'b1;
        step(4);
    endtask

    task automatic write_word(input reg_num_t r, input logic [15:0] w);
        logic [7:0] unused;
        bus_byte(1'b0, r, 1'b0, w[15:8], unused);
        bus_byte(1'b0, r, 1'b1, w[7:0], unused);
    endtask

    task automatic read_word(input reg_num_t r, output logic [15:0] w);
        bus_byte(1'b1, r, 1'b0, 8'h00, w[15:8]);
        bus_byte(1'b1, r, 1'b1, 8'h00, w[7:0]);
    endtask

    task automatic wait_idle();
        while (vram_sel_o) step(1);                                    // watchdog bounds this
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_mark = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == err_mark) begin
            $display("%-12s ok", cur_test);
        end else begin
            tests_failed++;
            $display("%-12s FAILED, %0d errors", cur_test, errors - err_mark);
        end
    endtask

    initial begin
        #(TOTAL_CYC * 2 * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [15:0] w;
        logic [15:0] base;
        logic [15:0] inc;
        logic [15:0] exp0;
        logic [15:0] exp1;
        logic [15:0] dq[$];
        int          n0;
        int          nr;
        int          stall;
        reg_num_t    dropped[4];

        for (int a = 0; a < 65536; a++) mem[a] = fill_word(16'(a));
        reset_i     = 1'b1;
        cs_n_i      = 1'b1;
        rd_nwr_i    = 1'b0;
        reg_num_i   = '0;
        bytesel_i   = 1'b0;
        data_i      = '0;
        vgen_sel_i  = 1'b0;
        vram_data_i = '0;
        repeat (2) @(posedge clk);
        #0.5;
        reset_i = 1'b0;
        step(1);

        // 1: everything cleared, mask all ones
        begin_test("reset");
        check_flag(!vram_sel_o, "vram_sel_o low after reset");
        check_word("mask", 16'h000F, 16'(vram_mask_o));
        read_word(XM_RD_INCR, w);
        check_word("RD_INCR", 16'h0000, w);
        read_word(XM_RD_ADDR, w);
        check_word("RD_ADDR", 16'h0000, w);
        read_word(XM_WR_INCR, w);
        check_word("WR_INCR", 16'h0000, w);
        read_word(XM_WR_ADDR, w);
        check_word("WR_ADDR", 16'h0000, w);
        read_word(XM_DATA, w);
        check_word("DATA", 16'h0000, w);
        read_word(XM_SYS_CTRL, w);
        check_word("SYS_CTRL", 16'h0F00, w);                          // mask in even byte
        end_test();

        // 2: posted writes, post-increment by WR_INCR
        begin_test("write_chan");
        base = 16'(rand_bits(16));
        inc  = 16'(rand_bits(3)) + 16'd1;
        write_word(XM_WR_INCR, inc);
        write_word(XM_WR_ADDR, base);
        n0 = wr_addr_q.size();
        for (int k = 0; k < 6; k++) begin
            w = 16'(rand_bits(16));
            dq.push_back(w);
            write_word((k % 2 == 0) ? XM_DATA : XM_DATA_2, w);
        end
        check_flag(wr_addr_q.size() == n0 + 6, "one vram write per DATA word");
        for (int k = 0; k < 6 && n0 + k < wr_addr_q.size(); k++) begin
            check_word("write addr", base + 16'(k) * inc, wr_addr_q[n0 + k]);
            check_word("write data", dq[k], wr_data_q[n0 + k]);
            check_word("write mask", 16'h000F, 16'(wr_mask_q[n0 + k]));
        end
        read_word(XM_WR_ADDR, w);
        check_word("final WR_ADDR", base + 16'd6 * inc, w);
        end_test();

        // 3: RD_ADDR load reads, odd DATA read prefetches
        begin_test("read_chan");
        base = 16'h8000 | 16'(rand_bits(12));
        inc  = 16'd2;
        exp0 = mem[base];
        exp1 = mem[base + inc];
        nr   = rd_addr_q.size();
        write_word(XM_RD_INCR, inc);
        write_word(XM_RD_ADDR, base);
        read_word(XM_DATA, w);
        check_word("first DATA", exp0, w);
        read_word(XM_DATA, w);
        check_word("second DATA", exp1, w);
        check_flag(rd_addr_q.size() == nr + 3, "three vram reads");
        if (rd_addr_q.size() == nr + 3) begin
            check_word("load read addr", base, rd_addr_q[nr]);
            check_word("prefetch addr", base + inc, rd_addr_q[nr + 1]);
            check_word("prefetch addr 2", base + 16'd2 * inc, rd_addr_q[nr + 2]);
        end
        read_word(XM_RD_ADDR, w);
        check_word("final RD_ADDR", base + 16'd3 * inc, w);
        end_test();

        // 4: high byte only from a matching even write
        begin_test("byte_asm");
        bus_byte(1'b0, XM_RD_INCR, 1'b1, 8'h5A, w[7:0]);
        read_word(XM_RD_INCR, w);
        check_word("odd only", 16'h005A, w);
        bus_byte(1'b0, XM_WR_INCR, 1'b0, 8'h77, w[7:0]);
        bus_byte(1'b0, XM_RD_INCR, 1'b1, 8'h3C, w[7:0]);
        read_word(XM_RD_INCR, w);
        check_word("other even", 16'h003C, w);
        write_word(XM_RD_INCR, 16'h1234);
        read_word(XM_RD_INCR, w);
        check_word("full word", 16'h1234, w);
        end_test();

        // 5: nibble mask, readback, dropped registers
        begin_test("mask_regs");
        write_word(XM_SYS_CTRL, 16'h0500);
        check_word("mask out", 16'h0005, 16'(vram_mask_o));
        read_word(XM_SYS_CTRL, w);
        check_word("SYS_CTRL", 16'h0500, w);
        n0 = wr_addr_q.size();
        write_word(XM_DATA, 16'(rand_bits(16)));
        check_flag(wr_addr_q.size() == n0 + 1, "masked DATA write recorded");
        if (wr_addr_q.size() == n0 + 1) check_word("write mask", 16'h0005, 16'(wr_mask_q[n0]));
        dropped = '{XM_XR_ADDR, XM_TIMER, XM_RW_ADDR, XM_RW_DATA};
        n0 = wr_addr_q.size();
        nr = rd_addr_q.size();
        foreach (dropped[i]) write_word(dropped[i], 16'hFFFF);
        foreach (dropped[i]) begin
            read_word(dropped[i], w);
            check_word("dropped reg", 16'h0000, w);
        end
        check_flag(wr_addr_q.size() == n0 && rd_addr_q.size() == nr, "no vram access");
        check_flag(!vram_sel_o, "vram_sel_o idle");
        check_word("mask kept", 16'h0005, 16'(vram_mask_o));
        write_word(XM_SYS_CTRL, 16'h0F00);
        end_test();

        // 6: video owns vram, request waits and lands once
        begin_test("stall");
        base = 16'(rand_bits(16));
        inc  = 16'(rand_bits(3)) + 16'd1;
        write_word(XM_WR_INCR, inc);
        write_word(XM_WR_ADDR, base);
        stall = int'(rand_bits(4)) + 2;
        n0 = wr_addr_q.size();
        vgen_sel_i = 1'b1;
        write_word(XM_DATA_2, 16'hC3A5);
        step(stall);
        check_flag(vram_sel_o, "request pending while stalled");
        check_flag(wr_addr_q.size() == n0, "no write while stalled");
        vgen_sel_i = 1'b0;
        wait_idle();
        step(2);
        check_flag(wr_addr_q.size() == n0 + 1, "exactly one write after the stall");
        if (wr_addr_q.size() == n0 + 1) check_word("stalled addr", base, wr_addr_q[n0]);
        read_word(XM_WR_ADDR, w);
        check_word("WR_ADDR once", base + inc, w);
        end_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
hw/xm_regs_pkg.sv
hw/vram_pkg.sv
hw/bus_sync.sv
hw/word_assembler.sv
hw/vram_access.sv
hw/readback_mux.sv
hw/xm_front_top.sv
verif/xm_front_sva.sv
verif/tb_xm_front.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_xm_front
FILELIST  = all.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Test passed"

clean:
	rm -rf obj_dir
